//--- rtl/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// fetch address and instruction word
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// address split into tag, index and offset
`define ICACHE_TAG_W 19
`define ICACHE_INDEX_W 7
`define ICACHE_OFFSET_W 6

// 8 KB direct mapped, 64 byte lines
`define ICACHE_LINES 128
// offset[5:4] picks the bank, offset[3:2] the word inside it
`define ICACHE_BANKS 4
`define ICACHE_BANK_W 128

// refill burst of one 32-bit beat per word of the line
`define ICACHE_BEATS 16
`define ICACHE_BURST_LEN_W 8
// addr[31:28] of the uncached I/O window
`define ICACHE_IO_REGION 4'h1

`endif

//--- rtl/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

  // address and its fields
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

  // payload widths
  typedef logic [`ICACHE_WORD_W-1:0] word_t;
  typedef logic [`ICACHE_BANK_W-1:0] bank_data_t;

  // selects and counters
  typedef logic [$clog2(`ICACHE_BANK_W / `ICACHE_WORD_W)-1:0] word_sel_t;
  typedef logic [$clog2(`ICACHE_BANKS)-1:0] bank_sel_t;
  typedef logic [$clog2(`ICACHE_BEATS)-1:0] beat_t;
  typedef logic [`ICACHE_BURST_LEN_W-1:0] burst_len_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED_READ,
    RESPOND
  } icache_state_e;

endpackage

//--- rtl/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_req_i,
  input  icache_pkg::addr_t       fetch_addr_i,
  input  logic                    hit_i,
  input  logic                    mem_rdata_valid_i,
  input  icache_pkg::word_t       mem_rdata_i,
  output logic                    fetch_valid_o,
  output icache_pkg::index_t      rd_index_o,
  output icache_pkg::offset_t     offset_o,
  output icache_pkg::tag_t        tag_o,
  output logic                    tag_wr_o,
  output logic [`ICACHE_BANKS-1:0] bank_wr_o,
  output icache_pkg::word_sel_t   wr_word_o,
  output icache_pkg::word_t       wr_data_o,
  output logic                    uncached_sel_o,
  output icache_pkg::word_t       uncached_word_o,
  output logic                    mem_req_valid_o,
  output icache_pkg::addr_t       mem_addr_o,
  output icache_pkg::burst_len_t  mem_len_o
);

  icache_pkg::icache_state_e state_q;
  icache_pkg::addr_t         addr_q;
  icache_pkg::beat_t         beat_q;
  icache_pkg::bank_sel_t     beat_bank;
  logic                      beat_fire;
  logic                      last_beat;
  logic                      io_access;

  // split of the captured fetch address
  assign tag_o      = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign rd_index_o = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign offset_o   = addr_q[`ICACHE_OFFSET_W-1:0];

  // top nibble selects the I/O window
  assign io_access = (addr_q[`ICACHE_ADDR_W-1 -: 4] == `ICACHE_IO_REGION);

  // a beat moves whenever both sides are valid
  assign beat_fire = mem_req_valid_o && mem_rdata_valid_i;
  assign last_beat = (beat_q == icache_pkg::beat_t'(`ICACHE_BEATS - 1));

  // beat k goes to bank k/4, word k mod 4
  assign beat_bank = beat_q[3:2];
  assign wr_word_o = beat_q[1:0];
  assign wr_data_o = mem_rdata_i;

  always_comb begin
    bank_wr_o = '0;
    if (state_q == icache_pkg::REFILL && beat_fire) begin
      bank_wr_o[beat_bank] = 1'b1;
    end
  end

  // tag and valid bit land with the final beat
  assign tag_wr_o = (state_q == icache_pkg::REFILL) && beat_fire && last_beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= icache_pkg::IDLE;
      fetch_valid_o   <= 1'b0;
      mem_req_valid_o <= 1'b0;
      uncached_sel_o  <= 1'b0;
      beat_q          <= '0;
    end else begin
      // response is a single cycle pulse
      fetch_valid_o <= 1'b0;
      case (state_q)
        icache_pkg::IDLE: begin
          // request is still up in the response cycle, skip it
          if (fetch_req_i && !fetch_valid_o) begin
            uncached_sel_o <= 1'b0;
            state_q        <= icache_pkg::LOOKUP;
          end
        end
        icache_pkg::LOOKUP: begin
          // I/O window wins over the tag compare
          if (io_access) begin
            mem_req_valid_o <= 1'b1;
            state_q         <= icache_pkg::UNCACHED_READ;
          end else if (hit_i) begin
            state_q <= icache_pkg::RESPOND;
          end else begin
            mem_req_valid_o <= 1'b1;
            beat_q          <= '0;
            state_q         <= icache_pkg::REFILL;
          end
        end
        icache_pkg::REFILL: begin
          if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              // look the now valid line up again
              mem_req_valid_o <= 1'b0;
              state_q         <= icache_pkg::LOOKUP;
            end
          end
        end
        icache_pkg::UNCACHED_READ: begin
          if (beat_fire) begin
            mem_req_valid_o <= 1'b0;
            uncached_sel_o  <= 1'b1;
            fetch_valid_o   <= 1'b1;
            state_q         <= icache_pkg::IDLE;
          end
        end
        icache_pkg::RESPOND: begin
          // bank read data is settled by now
          fetch_valid_o <= 1'b1;
          state_q       <= icache_pkg::IDLE;
        end
        default: begin
          state_q <= icache_pkg::IDLE;
        end
      endcase
    end
  end

  // address, burst descriptor and uncached word
  always_ff @(posedge clk) begin
    if (state_q == icache_pkg::IDLE && fetch_req_i && !fetch_valid_o) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == icache_pkg::LOOKUP) begin
      if (io_access) begin
        // exact address, single beat
        mem_addr_o <= addr_q;
        mem_len_o  <= '0;
      end else begin
        // line aligned, full burst
        mem_addr_o <= {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        mem_len_o  <= icache_pkg::burst_len_t'(`ICACHE_BEATS - 1);
      end
    end
    if (state_q == icache_pkg::UNCACHED_READ && beat_fire) begin
      uncached_word_o <= mem_rdata_i;
    end
  end

endmodule

//--- rtl/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tag_array (
  input  logic                clk,
  input  logic                rst,
  input  icache_pkg::index_t  index_i,
  input  icache_pkg::tag_t    tag_i,
  input  logic                wr_i,
  output logic                hit_o
);

  // one valid bit per line
  logic [`ICACHE_LINES-1:0] valid_q;
  // stored tags
  icache_pkg::tag_t         tags_q [`ICACHE_LINES];
  logic                     tag_match;

  // valid bits start cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // tag written alongside its valid bit
  always_ff @(posedge clk) begin
    if (wr_i) begin
      tags_q[index_i] <= tag_i;
    end
  end

  // compare against the indexed entry
  assign tag_match = (tags_q[index_i] == tag_i);

  // combinational on the index
  assign hit_o = valid_q[index_i] && tag_match;

endmodule

//--- rtl/icache_data_bank.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_data_bank (
  input  logic                   clk,
  input  logic                   wr_i,
  input  icache_pkg::index_t     wr_index_i,
  input  icache_pkg::word_sel_t  wr_word_i,
  input  icache_pkg::word_t      wr_data_i,
  input  icache_pkg::index_t     rd_index_i,
  output icache_pkg::bank_data_t rd_data_o
);

  // four words of each line live here
  icache_pkg::bank_data_t mem_q [`ICACHE_LINES];

  // word masked write keeps the rest of the entry
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem_q[wr_index_i][wr_word_i*`ICACHE_WORD_W +: `ICACHE_WORD_W] <= wr_data_i;
    end
  end

  // registered read takes one cycle like an SRAM macro
  // old data on a same-edge write to the read entry
  always_ff @(posedge clk) begin
    rd_data_o <= mem_q[rd_index_i];
  end

endmodule

//--- rtl/icache_fetch_mux.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_fetch_mux (
  input  icache_pkg::bank_data_t bank_data_i [`ICACHE_BANKS],
  input  icache_pkg::offset_t    offset_i,
  input  logic                   uncached_sel_i,
  input  icache_pkg::word_t      uncached_word_i,
  output icache_pkg::word_t      fetch_data_o
);

  icache_pkg::bank_sel_t  bank_sel;
  icache_pkg::word_sel_t  word_sel;
  icache_pkg::bank_data_t bank_line;
  icache_pkg::word_t      cached_word;

  // offset[5:4] bank, offset[3:2] word
  assign bank_sel = offset_i[5:4];
  assign word_sel = offset_i[3:2];

  assign bank_line   = bank_data_i[bank_sel];
  assign cached_word = bank_line[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

  // uncached reply bypasses the banks
  assign fetch_data_o = uncached_sel_i ? uncached_word_i : cached_word;

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_top (
  input  logic                    clk,
  input  logic                    rst,
  // fetch side
  input  logic                    fetch_req_i,
  input  icache_pkg::addr_t       fetch_addr_i,
  output logic                    fetch_valid_o,
  output icache_pkg::word_t       fetch_data_o,
  // memory side
  output logic                    mem_req_valid_o,
  output icache_pkg::addr_t       mem_addr_o,
  output icache_pkg::burst_len_t  mem_len_o,
  input  logic                    mem_rdata_valid_i,
  input  icache_pkg::word_t       mem_rdata_i
);

  // controller to tag array and banks
  logic                         hit;
  icache_pkg::index_t           rd_index;
  icache_pkg::offset_t          offset;
  icache_pkg::tag_t             tag;
  logic                         tag_wr;
  logic [`ICACHE_BANKS-1:0]     bank_wr;
  icache_pkg::word_sel_t        wr_word;
  icache_pkg::word_t            wr_data;
  // uncached path into the fetch mux
  logic                         uncached_sel;
  icache_pkg::word_t            uncached_word;
  // bank read data
  icache_pkg::bank_data_t       bank_rdata [`ICACHE_BANKS];

  icache_ctrl u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .fetch_req_i       (fetch_req_i),
    .fetch_addr_i      (fetch_addr_i),
    .hit_i             (hit),
    .mem_rdata_valid_i (mem_rdata_valid_i),
    .mem_rdata_i       (mem_rdata_i),
    .fetch_valid_o     (fetch_valid_o),
    .rd_index_o        (rd_index),
    .offset_o          (offset),
    .tag_o             (tag),
    .tag_wr_o          (tag_wr),
    .bank_wr_o         (bank_wr),
    .wr_word_o         (wr_word),
    .wr_data_o         (wr_data),
    .uncached_sel_o    (uncached_sel),
    .uncached_word_o   (uncached_word),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_addr_o        (mem_addr_o),
    .mem_len_o         (mem_len_o)
  );

  icache_tag_array u_tag_array (
    .clk     (clk),
    .rst     (rst),
    .index_i (rd_index),
    .tag_i   (tag),
    .wr_i    (tag_wr),
    .hit_o   (hit)
  );

  // refill writes and lookups share the captured index
  for (genvar g = 0; g < `ICACHE_BANKS; g++) begin : g_bank
    icache_data_bank u_bank (
      .clk        (clk),
      .wr_i       (bank_wr[g]),
      .wr_index_i (rd_index),
      .wr_word_i  (wr_word),
      .wr_data_i  (wr_data),
      .rd_index_i (rd_index),
      .rd_data_o  (bank_rdata[g])
    );
  end

  icache_fetch_mux u_fetch_mux (
    .bank_data_i     (bank_rdata),
    .offset_i        (offset),
    .uncached_sel_i  (uncached_sel),
    .uncached_word_i (uncached_word),
    .fetch_data_o    (fetch_data_o)
  );

endmodule

//--- verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10;
      clk_o = ~clk_o;
    end
  end

  // reset high over the first 8 rising edges
  initial begin
    rst_o <= 1'b1;
    repeat (8) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- verification/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mem_req_valid_i,
  input  icache_pkg::addr_t      mem_addr_i,
  input  icache_pkg::burst_len_t mem_len_i,
  output logic                   mem_rdata_valid_o,
  output icache_pkg::word_t      mem_rdata_o,
  output int                     req_count_o,
  output icache_pkg::addr_t      last_addr_o,
  output icache_pkg::burst_len_t last_len_o
);

  integer            seed;
  logic              busy;
  icache_pkg::addr_t beat_addr;
  int                beats_left;
  int                stall;

  // contents are the byte address with its upper half inverted
  function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  initial begin
    seed              = 32'h5fc;
    busy              = 1'b0;
    beat_addr         = '0;
    beats_left        = 0;
    stall             = 0;
    mem_rdata_valid_o = 1'b0;
    mem_rdata_o       = '0;
    req_count_o       = 0;
    last_addr_o       = '0;
    last_len_o        = '0;
    forever begin
      @(posedge clk);
      // outputs move just after the edge
      #1;
      if (rst) begin
        busy              = 1'b0;
        mem_rdata_valid_o = 1'b0;
      end else begin
        // the presented beat was taken at this edge
        // request stays up until the last beat
        if (mem_rdata_valid_o) begin
          mem_rdata_valid_o = 1'b0;
          beat_addr         = beat_addr + 32'd4;
          beats_left        = beats_left - 1;
          if (beats_left == 0) begin
            busy = 1'b0;
          end else begin
            stall = $random(seed) & 3;
          end
        end
        // log a new burst and pick its first stall
        if (!busy && mem_req_valid_i) begin
          busy        = 1'b1;
          beat_addr   = mem_addr_i;
          beats_left  = int'(mem_len_i) + 1;
          req_count_o = req_count_o + 1;
          last_addr_o = mem_addr_i;
          last_len_o  = mem_len_i;
          stall       = $random(seed) & 3;
        end
        // 0..3 idle cycles before each beat
        if (busy && !mem_rdata_valid_o) begin
          if (stall == 0) begin
            mem_rdata_valid_o = 1'b1;
            mem_rdata_o       = mem_word(beat_addr);
          end else begin
            stall = stall - 1;
          end
        end
      end
    end
  end

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb;

  localparam int NUM_TESTS = 13;
  localparam int KIND_HIT  = 0;
  localparam int KIND_MISS = 1;
  localparam int KIND_IO   = 2;
  // per-wait cycle limit
  localparam int MAX_WAIT  = 200;

  logic                   clk;
  logic                   rst;
  logic                   fetch_req;
  icache_pkg::addr_t      fetch_addr;
  logic                   fetch_valid;
  icache_pkg::word_t      fetch_data;
  logic                   mem_req_valid;
  icache_pkg::addr_t      mem_addr;
  icache_pkg::burst_len_t mem_len;
  logic                   mem_rdata_valid;
  icache_pkg::word_t      mem_rdata;
  // request log from the memory model
  int                     mem_req_count;
  icache_pkg::addr_t      last_addr;
  icache_pkg::burst_len_t last_len;

  // stimulus table of start address, expected kind and word count
  icache_pkg::addr_t stim_addr [NUM_TESTS];
  int                stim_kind [NUM_TESTS];
  int                stim_words [NUM_TESTS];

  int   errors;
  int   checks;
  int   fetches;
  int   pulses = 0;
  logic timed_out;

  tb_clkgen u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  icache_top u_dut (
    .clk               (clk),
    .rst               (rst),
    .fetch_req_i       (fetch_req),
    .fetch_addr_i      (fetch_addr),
    .fetch_valid_o     (fetch_valid),
    .fetch_data_o      (fetch_data),
    .mem_req_valid_o   (mem_req_valid),
    .mem_addr_o        (mem_addr),
    .mem_len_o         (mem_len),
    .mem_rdata_valid_i (mem_rdata_valid),
    .mem_rdata_i       (mem_rdata)
  );

  icache_mem_model u_mem (
    .clk               (clk),
    .rst               (rst),
    .mem_req_valid_i   (mem_req_valid),
    .mem_addr_i        (mem_addr),
    .mem_len_i         (mem_len),
    .mem_rdata_valid_o (mem_rdata_valid),
    .mem_rdata_o       (mem_rdata),
    .req_count_o       (mem_req_count),
    .last_addr_o       (last_addr),
    .last_len_o        (last_len)
  );

  // response pulses counted mid cycle
  always @(negedge clk) begin
    if (!rst && fetch_valid) begin
      pulses = pulses + 1;
    end
  end

  // memory rule inverts the upper 16 address bits
  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      KIND_HIT: return "hit";
      KIND_MISS: return "miss";
      default: return "uncached";
    endcase
  endfunction

  task automatic add_entry(input int idx, input icache_pkg::addr_t addr, input int kind,
                           input int words);
    stim_addr[idx]  = addr;
    stim_kind[idx]  = kind;
    stim_words[idx] = words;
  endtask

  task automatic fill_table();
    // cold miss, then every word of that line from the cache
    add_entry(0, 32'h0000_1040, KIND_MISS, 1);
    add_entry(1, 32'h0000_1040, KIND_HIT, 16);
    // I/O window twice and never allocated
    add_entry(2, 32'h1000_0204, KIND_IO, 1);
    add_entry(3, 32'h1000_0204, KIND_IO, 1);
    // index 2 with tags 0x1 and 0x21 evict each other
    add_entry(4, 32'h0000_2080, KIND_MISS, 1);
    add_entry(5, 32'h0004_2080, KIND_MISS, 1);
    add_entry(6, 32'h0000_2084, KIND_MISS, 1);
    add_entry(7, 32'h0004_208c, KIND_MISS, 1);
    add_entry(8, 32'h0004_2090, KIND_HIT, 1);
    // index 0x41 untouched by the conflict pair
    add_entry(9, 32'h0000_1044, KIND_HIT, 1);
    // last word of a line at index 0x5f
    add_entry(10, 32'h0003_f7fc, KIND_MISS, 1);
    add_entry(11, 32'h1abc_def0, KIND_IO, 1);
    add_entry(12, 32'h0003_f7c0, KIND_HIT, 4);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  // no request, so nothing may move on either side
  task automatic check_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      #1;
      check_flag(!fetch_valid, "fetch_valid_o went high with no request");
      check_flag(!mem_req_valid, "mem_req_valid_o went high with no request");
    end
  endtask

  task automatic do_fetch(input icache_pkg::addr_t addr, input int kind);
    int req_before;
    int cycles;
    @(posedge clk);
    #1;
    // previous response was a single pulse
    check_flag(!fetch_valid, "fetch_valid_o stayed high for more than one cycle");
    check_value("fetch_valid_o pulse count", pulses, fetches);
    req_before = mem_req_count;
    fetch_req  = 1'b1;
    fetch_addr = addr;
    cycles     = 0;
    while (!fetch_valid && cycles < MAX_WAIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    fetch_req = 1'b0;
    fetches++;
    if (!fetch_valid) begin
      $display("Error: no response to the fetch of %h within %0d cycles", addr, MAX_WAIT);
      errors++;
      timed_out = 1'b1;
    end else begin
      check_value("fetch_data_o", fetch_data, expected_word(addr));
      case (kind)
        KIND_HIT: begin
          // first counted edge is the accepting one
          check_value("fetch latency", cycles - 1, 2);
          check_value("memory request count", mem_req_count, req_before);
        end
        KIND_MISS: begin
          check_value("memory request count", mem_req_count, req_before + 1);
          // start of the 64 byte line
          check_value("mem_addr_o", last_addr, addr & ~32'h3f);
          check_value("mem_len_o", 32'(last_len), `ICACHE_BEATS - 1);
        end
        default: begin
          check_value("memory request count", mem_req_count, req_before + 1);
          check_value("mem_addr_o", last_addr, addr);
          check_value("mem_len_o", 32'(last_len), 0);
        end
      endcase
    end
  endtask

  initial begin
    int guard;
    int errors_before;
    int tests;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    errors     = 0;
    checks     = 0;
    fetches    = 0;
    tests      = 0;
    timed_out  = 1'b0;
    fill_table();
    guard = 0;
    while (rst && guard < 50) begin
      @(posedge clk);
      #1;
      guard++;
    end
    check_flag(!rst, "reset was never released");
    errors_before = errors;
    check_idle(10);
    tests++;
    $display("idle after reset: %s", (errors == errors_before) ? "ok" : "FAILED");
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      errors_before = errors;
      for (int w = 0; w < stim_words[t] && !timed_out; w++) begin
        do_fetch(stim_addr[t] + 32'(w * 4), stim_kind[t]);
      end
      tests++;
      $display("test %0d: %s at %h, %0d word(s): %s", t, kind_name(stim_kind[t]),
               stim_addr[t], stim_words[t], (errors == errors_before) ? "ok" : "FAILED");
    end
    // last response must also be a single pulse
    @(posedge clk);
    #1;
    check_value("fetch_valid_o pulse count", pulses, fetches);
    $display("tests %0d, fetches %0d, checks %0d, errors %0d", tests, fetches, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_ctrl.sv
rtl/icache_tag_array.sv
rtl/icache_data_bank.sv
rtl/icache_fetch_mux.sv
rtl/icache_top.sv
verification/tb_clkgen.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

//--- run.sh
#!/bin/sh
# build the icache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module icache_tb \
  -o icache_sim > sim.log 2>&1 \
  && ./obj_dir/icache_sim >> sim.log 2>&1 \
  || echo "Regression failed" >> sim.log

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
